//--- rtl/host_ctrl_defines.svh
// Shared constants of the host command controller
//   Host command IDs and reply IDs
//   Largest command payload in bytes
//   Port, I/O module and register counts

`ifndef HOST_CTRL_DEFINES_SVH
`define HOST_CTRL_DEFINES_SVH

// Command IDs accepted on the command endpoint
`define CMD_GET_HWCON 8'h33
`define CMD_SET_HWCON 8'h34
`define CMD_GET_IOREG 8'h35
`define CMD_SET_IOREG 8'h36

// Reply IDs sent on the reply endpoint
`define RPL_DATA_HWCON 8'h91
`define RPL_DATA_IOREG 8'h92

// Payload buffer size, commands carry 1 to this many bytes
`define MAX_CMD_BYTES 8

// One hardware configuration register per port
`define NUM_PORTS 4

// An input and an output module per port, each with its own register bank
`define NUM_IO_MODULES 8
`define NUM_IO_REGS 4

`endif

//--- rtl/host_ctrl_pkg.sv
// Shared types of the host command controller
//   Command and reply IDs, payload lengths and payload buffers
//   Port numbers, I/O module selects and register addresses

`default_nettype none

`include "host_ctrl_defines.svh"

package host_ctrl_pkg;

    // Command or reply ID
    typedef logic [7:0] cmd_id_t;

    // Payload length in bytes
    typedef logic [15:0] cmd_len_t;

    // Payload bytes, byte i in bits 8i+7 down to 8i
    typedef logic [8*`MAX_CMD_BYTES-1:0] cmd_buf_t;

    // Hardware port number
    typedef logic [$clog2(`NUM_PORTS)-1:0] port_t;

    // One-hot I/O module select
    // Bits 7..4 are the input modules of ports 3..0,
    // bits 3..0 the output modules of ports 3..0
    typedef logic [`NUM_IO_MODULES-1:0] io_sel_t;

    // Register address inside one I/O module
    typedef logic [$clog2(`NUM_IO_REGS)-1:0] io_addr_t;

endpackage

`default_nettype wire

//--- rtl/cmd_receiver.sv
// Command receiver
//   Collects the payload of one command from the command endpoint
//   Hands ID and payload to the executor with a one-cycle valid pulse

`default_nettype none

`include "host_ctrl_defines.svh"

module cmd_receiver (
    input  logic                     clk,
    input  logic                     reset,
    input  host_ctrl_pkg::cmd_id_t   ep4_cmd_id,
    input  host_ctrl_pkg::cmd_len_t  ep4_cmd_length,
    input  logic                     ep4_ready,
    input  logic [7:0]               ep4_data,
    output logic                     ep4_read,
    input  logic                     busy,
    output logic                     cmd_valid,
    output host_ctrl_pkg::cmd_id_t   cmd_id,
    output host_ctrl_pkg::cmd_buf_t  cmd_data
);
    import host_ctrl_pkg::*;

    typedef enum logic {
        IDLE,
        COLLECT
    } rx_state_t;

    rx_state_t state;
    cmd_len_t  count;
    logic      start;
    logic      last_taken;

    // Stay idle while the executor works and in the cycle of our own pulse
    assign start      = (state == IDLE) && !busy && !cmd_valid;
    assign ep4_read   = (state == COLLECT) && ep4_ready && (count < ep4_cmd_length);
    assign last_taken = (state == COLLECT) && (count == ep4_cmd_length);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= IDLE;
            count     <= '0;
            cmd_valid <= 1'b0;
        end else begin
            cmd_valid <= 1'b0;
            case (state)
                IDLE: begin
                    if (start) begin
                        state <= COLLECT;
                        count <= '0;
                    end
                end
                COLLECT: begin
                    if (last_taken) begin
                        cmd_valid <= 1'b1;
                        state     <= IDLE;
                    end else if (ep4_read) begin
                        count <= count + 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Payload buffer, byte goes to the slot given by the byte count
    always_ff @(posedge clk) begin
        if (start) begin
            cmd_data <= '0;
        end else if (ep4_read) begin
            for (int i = 0; i < `MAX_CMD_BYTES; i++) begin
                if (count == cmd_len_t'(i))
                    cmd_data[8*i +: 8] <= ep4_data;
            end
        end
        if (last_taken)
            cmd_id <= ep4_cmd_id;
    end

endmodule

`default_nettype wire

//--- rtl/cmd_executor.sv
// Command executor
//   Decodes commands from the receiver
//   Holds the four hardware configuration registers
//   Reads and writes I/O module registers over the configuration bus
//   Builds data replies for the reply sender

`default_nettype none

`include "host_ctrl_defines.svh"

module cmd_executor (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     cmd_valid,
    input  host_ctrl_pkg::cmd_id_t   cmd_id,
    input  host_ctrl_pkg::cmd_buf_t  cmd_data,
    output logic                     busy,
    input  logic [3:0]               direction,
    output logic [31:0]              hwcons,
    output host_ctrl_pkg::io_sel_t   cfg_io_write,
    output host_ctrl_pkg::io_sel_t   cfg_io_read,
    output host_ctrl_pkg::io_addr_t  cfg_io_addr,
    output logic [7:0]               cfg_io_wdata,
    input  logic [7:0]               cfg_io_rdata,
    output logic                     rpl_valid,
    output host_ctrl_pkg::cmd_id_t   rpl_id,
    output host_ctrl_pkg::cmd_len_t  rpl_length,
    output host_ctrl_pkg::cmd_buf_t  rpl_data,
    input  logic                     rpl_done
);
    import host_ctrl_pkg::*;

    localparam cmd_len_t HWCON_RPL_LEN = 16'd2;
    localparam cmd_len_t IOREG_RPL_LEN = 16'd3;

    typedef enum logic [1:0] {
        EX_IDLE,
        EX_IO_READ,
        EX_REPLY,
        EX_FINISH
    } ex_state_t;

    ex_state_t state;

    logic [7:0] hwcon [`NUM_PORTS];

    // Command fields, byte 0 is always the port
    port_t      cmd_port;
    logic [7:0] cmd_arg1;
    logic [7:0] cmd_arg2;
    io_addr_t   cmd_addr;

    logic [$clog2(`NUM_IO_MODULES)-1:0] io_index;
    io_sel_t                            io_sel;

    assign cmd_port = cmd_data[1:0];
    assign cmd_arg1 = cmd_data[15:8];
    assign cmd_arg2 = cmd_data[23:16];
    assign cmd_addr = cmd_arg1[1:0];

    // Module index is the port direction on top of the port number
    assign io_index = {direction[cmd_port], cmd_port};
    assign io_sel   = io_sel_t'(1) << io_index;

    always_comb begin
        for (int p = 0; p < `NUM_PORTS; p++)
            hwcons[8*p +: 8] = hwcon[p];
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state        <= EX_IDLE;
            busy         <= 1'b0;
            cfg_io_write <= '0;
            cfg_io_read  <= '0;
            rpl_valid    <= 1'b0;
            for (int p = 0; p < `NUM_PORTS; p++)
                hwcon[p] <= '0;
        end else begin
            // Strobes last a single cycle
            cfg_io_write <= '0;
            cfg_io_read  <= '0;
            rpl_valid    <= 1'b0;
            case (state)
                EX_IDLE: begin
                    if (cmd_valid) begin
                        busy  <= 1'b1;
                        state <= EX_FINISH;
                        case (cmd_id)
                            `CMD_SET_HWCON: hwcon[cmd_port] <= cmd_arg1;
                            `CMD_GET_HWCON: begin
                                rpl_valid <= 1'b1;
                                state     <= EX_REPLY;
                            end
                            `CMD_SET_IOREG: cfg_io_write <= io_sel;
                            `CMD_GET_IOREG: begin
                                cfg_io_read <= io_sel;
                                state       <= EX_IO_READ;
                            end
                            // Unknown IDs just finish, nothing is sent back
                            default: state <= EX_FINISH;
                        endcase
                    end
                end
                EX_IO_READ: begin
                    rpl_valid <= 1'b1;
                    state     <= EX_REPLY;
                end
                EX_REPLY: begin
                    if (rpl_done) begin
                        busy  <= 1'b0;
                        state <= EX_IDLE;
                    end
                end
                EX_FINISH: begin
                    busy  <= 1'b0;
                    state <= EX_IDLE;
                end
                default: state <= EX_IDLE;
            endcase
        end
    end

    // Bus and reply payload
    always_ff @(posedge clk) begin
        if (state == EX_IDLE && cmd_valid) begin
            cfg_io_addr  <= cmd_addr;
            cfg_io_wdata <= cmd_arg2;
            // Hardware configuration reply: value, then port
            rpl_id     <= `RPL_DATA_HWCON;
            rpl_length <= HWCON_RPL_LEN;
            rpl_data   <= cmd_buf_t'({8'(cmd_port), hwcon[cmd_port]});
        end
        // Read data is valid in the strobe cycle and taken at its closing edge
        if (state == EX_IO_READ) begin
            rpl_id     <= `RPL_DATA_IOREG;
            rpl_length <= IOREG_RPL_LEN;
            rpl_data   <= cmd_buf_t'({8'(cmd_port), 8'(cfg_io_addr), cfg_io_rdata});
        end
    end

endmodule

`default_nettype wire

//--- rtl/reply_sender.sv
// Reply sender
//   Latches one reply from the executor
//   Streams its bytes out of the reply endpoint, highest index first
//   Signals the end of the reply with a one-cycle done pulse

`default_nettype none

`include "host_ctrl_defines.svh"

module reply_sender (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     rpl_valid,
    input  host_ctrl_pkg::cmd_id_t   rpl_id,
    input  host_ctrl_pkg::cmd_len_t  rpl_length,
    input  host_ctrl_pkg::cmd_buf_t  rpl_data,
    output logic                     rpl_done,
    input  logic                     ep8_ready,
    output logic                     ep8_write,
    output logic [7:0]               ep8_data,
    output host_ctrl_pkg::cmd_id_t   ep8_cmd_id,
    output host_ctrl_pkg::cmd_len_t  ep8_cmd_length
);
    import host_ctrl_pkg::*;

    localparam int IDX_W = $clog2(`MAX_CMD_BYTES);

    logic             active;
    cmd_buf_t         rpl_buf;
    cmd_len_t         count;
    cmd_len_t         next_count;
    logic [IDX_W-1:0] byte_idx;

    // count holds the bytes still to go, the next byte sits at count-1
    assign next_count = count - cmd_len_t'(1);
    assign byte_idx   = next_count[IDX_W-1:0];

    assign ep8_write = active && ep8_ready;
    assign ep8_data  = rpl_buf[8*byte_idx +: 8];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            active   <= 1'b0;
            count    <= '0;
            rpl_done <= 1'b0;
        end else begin
            rpl_done <= 1'b0;
            if (!active) begin
                if (rpl_valid) begin
                    active <= 1'b1;
                    count  <= rpl_length;
                end
            end else if (ep8_write) begin
                count <= next_count;
                if (count == cmd_len_t'(1)) begin
                    active   <= 1'b0;
                    rpl_done <= 1'b1;
                end
            end
        end
    end

    // Reply header and bytes stay put for the whole transfer
    always_ff @(posedge clk) begin
        if (!active && rpl_valid) begin
            rpl_buf        <= rpl_data;
            ep8_cmd_id     <= rpl_id;
            ep8_cmd_length <= rpl_length;
        end
    end

endmodule

`default_nettype wire

//--- rtl/host_controller.sv
// Host command controller top level
//   Command receiver on the command endpoint
//   Command executor with hardware configuration and I/O register bus
//   Reply sender on the reply endpoint

`default_nettype none

module host_controller (
    input  logic                     clk,
    input  logic                     reset,
    // Command endpoint
    input  host_ctrl_pkg::cmd_id_t   ep4_cmd_id,
    input  host_ctrl_pkg::cmd_len_t  ep4_cmd_length,
    input  logic                     ep4_ready,
    input  logic [7:0]               ep4_data,
    output logic                     ep4_read,
    // Reply endpoint
    output host_ctrl_pkg::cmd_id_t   ep8_cmd_id,
    output host_ctrl_pkg::cmd_len_t  ep8_cmd_length,
    input  logic                     ep8_ready,
    output logic                     ep8_write,
    output logic [7:0]               ep8_data,
    // Port status and hardware configuration
    input  logic [3:0]               direction,
    output logic [31:0]              hwcons,
    // I/O module register bus
    output host_ctrl_pkg::io_sel_t   cfg_io_write,
    output host_ctrl_pkg::io_sel_t   cfg_io_read,
    output host_ctrl_pkg::io_addr_t  cfg_io_addr,
    output logic [7:0]               cfg_io_wdata,
    input  logic [7:0]               cfg_io_rdata
);
    import host_ctrl_pkg::*;

    logic     busy;
    logic     cmd_valid;
    cmd_id_t  cmd_id;
    cmd_buf_t cmd_data;
    logic     rpl_valid;
    cmd_id_t  rpl_id;
    cmd_len_t rpl_length;
    cmd_buf_t rpl_data;
    logic     rpl_done;

    cmd_receiver receiver0 (
        .clk            (clk),
        .reset          (reset),
        .ep4_cmd_id     (ep4_cmd_id),
        .ep4_cmd_length (ep4_cmd_length),
        .ep4_ready      (ep4_ready),
        .ep4_data       (ep4_data),
        .ep4_read       (ep4_read),
        .busy           (busy),
        .cmd_valid      (cmd_valid),
        .cmd_id         (cmd_id),
        .cmd_data       (cmd_data)
    );

    cmd_executor executor0 (
        .clk          (clk),
        .reset        (reset),
        .cmd_valid    (cmd_valid),
        .cmd_id       (cmd_id),
        .cmd_data     (cmd_data),
        .busy         (busy),
        .direction    (direction),
        .hwcons       (hwcons),
        .cfg_io_write (cfg_io_write),
        .cfg_io_read  (cfg_io_read),
        .cfg_io_addr  (cfg_io_addr),
        .cfg_io_wdata (cfg_io_wdata),
        .cfg_io_rdata (cfg_io_rdata),
        .rpl_valid    (rpl_valid),
        .rpl_id       (rpl_id),
        .rpl_length   (rpl_length),
        .rpl_data     (rpl_data),
        .rpl_done     (rpl_done)
    );

    reply_sender sender0 (
        .clk            (clk),
        .reset          (reset),
        .rpl_valid      (rpl_valid),
        .rpl_id         (rpl_id),
        .rpl_length     (rpl_length),
        .rpl_data       (rpl_data),
        .rpl_done       (rpl_done),
        .ep8_ready      (ep8_ready),
        .ep8_write      (ep8_write),
        .ep8_data       (ep8_data),
        .ep8_cmd_id     (ep8_cmd_id),
        .ep8_cmd_length (ep8_cmd_length)
    );

endmodule

`default_nettype wire

//--- dv/host_controller_properties.sv
// Bound assertions for the host command controller
//   Endpoint strobes only together with their ready levels
//   I/O register bus strobes at most one-hot and never together

`default_nettype none

module host_controller_properties (
    input logic                   clk,
    input logic                   reset,
    input logic                   ep4_ready,
    input logic                   ep4_read,
    input logic                   ep8_ready,
    input logic                   ep8_write,
    input host_ctrl_pkg::io_sel_t cfg_io_write,
    input host_ctrl_pkg::io_sel_t cfg_io_read
);

    ep4_read_with_ready: assert property (@(posedge clk) disable iff (reset)
        ep4_read |-> ep4_ready)
        else $error("ep4_read high while ep4_ready is low");

    ep8_write_with_ready: assert property (@(posedge clk) disable iff (reset)
        ep8_write |-> ep8_ready)
        else $error("ep8_write high while ep8_ready is low");

    io_write_onehot: assert property (@(posedge clk) disable iff (reset)
        $onehot0(cfg_io_write))
        else $error("cfg_io_write selects more than one module");

    io_read_onehot: assert property (@(posedge clk) disable iff (reset)
        $onehot0(cfg_io_read))
        else $error("cfg_io_read selects more than one module");

    // A bus cycle is either a read or a write
    io_strobes_apart: assert property (@(posedge clk) disable iff (reset)
        !((cfg_io_write != '0) && (cfg_io_read != '0)))
        else $error("cfg_io_write and cfg_io_read active in the same cycle");

endmodule

bind host_controller host_controller_properties props0 (.*);

`default_nettype wire

//--- dv/host_controller_tb.sv
// Testbench for the host command controller
//   Clock, reset and random command stimulus on the command endpoint
//   Random ready levels on both endpoints
//   Model of the eight I/O modules on the register bus
//   Expected hardware configuration and register contents with per-command checks
//   Watchdog

`default_nettype none

`include "host_ctrl_defines.svh"

module host_controller_tb;
    import host_ctrl_pkg::*;

    localparam int PERIOD     = 8;
    localparam int NUM_CMDS   = 200;
    localparam int CMD_CYCLES = 200;

    logic       clk;
    logic       reset;
    cmd_id_t    ep4_cmd_id;
    cmd_len_t   ep4_cmd_length;
    logic       ep4_ready;
    logic [7:0] ep4_data;
    logic       ep4_read;
    cmd_id_t    ep8_cmd_id;
    cmd_len_t   ep8_cmd_length;
    logic       ep8_ready;
    logic       ep8_write;
    logic [7:0] ep8_data;
    logic [3:0] direction;
    logic [31:0] hwcons;
    io_sel_t    cfg_io_write;
    io_sel_t    cfg_io_read;
    io_addr_t   cfg_io_addr;
    logic [7:0] cfg_io_wdata;
    logic [7:0] cfg_io_rdata;

    integer     seed;
    integer     ready_seed;
    logic       sending;
    logic       ep4_ready_roll;

    // I/O module contents as seen on the bus and as expected
    logic [7:0] io_mem [`NUM_IO_MODULES][`NUM_IO_REGS];
    logic [7:0] exp_io [`NUM_IO_MODULES][`NUM_IO_REGS];
    logic [7:0] exp_hwcon [`NUM_PORTS];
    logic [7:0] exp_bytes [$];
    logic [7:0] rpl_bytes [$];

    cmd_id_t    exp_rpl_id;
    cmd_id_t    seen_rpl_id;
    cmd_len_t   seen_rpl_len;
    io_sel_t    seen_wsel;
    io_sel_t    seen_rsel;
    io_sel_t    exp_sel;
    io_addr_t   seen_waddr;
    int         read_pulses;
    int         write_strobes;
    int         read_strobes;
    int         errors;
    int         errors_before;
    int         passed;

    cmd_id_t    id;
    int         len;
    int         kind;
    int         waited;
    cmd_buf_t   payload;
    port_t      port;
    io_addr_t   addr;
    logic [2:0] mod_idx;

    host_controller dut0 (.*);

    always #(PERIOD / 2) clk = ~clk;

    assign ep4_ready = sending && ep4_ready_roll;

    // Ready levels for both endpoints redrawn at every falling edge
    always @(negedge clk) begin
        ep4_ready_roll = ($random(ready_seed) & 3) != 0;
        ep8_ready      = ($random(ready_seed) & 3) != 0;
    end

    // I/O modules answer a read strobe in the same cycle
    always_comb begin
        cfg_io_rdata = 8'h00;
        for (int m = 0; m < `NUM_IO_MODULES; m++) begin
            if (cfg_io_read[m])
                cfg_io_rdata = io_mem[m][cfg_io_addr];
        end
    end

    // Endpoint and bus monitor that also acts as the write side of the I/O modules
    always @(posedge clk) begin
        if (!reset) begin
            if (ep4_read && !ep4_ready) begin
                $display("ep4_read pulsed at %0t while ep4_ready was low", $time);
                errors++;
            end
            if (ep8_write && !ep8_ready) begin
                $display("ep8_write pulsed at %0t while ep8_ready was low", $time);
                errors++;
            end
            if (ep4_read)
                read_pulses++;
            if (ep8_write) begin
                rpl_bytes.push_back(ep8_data);
                seen_rpl_id  = ep8_cmd_id;
                seen_rpl_len = ep8_cmd_length;
            end
            if (cfg_io_write != '0) begin
                write_strobes++;
                seen_wsel  = cfg_io_write;
                seen_waddr = cfg_io_addr;
                for (int m = 0; m < `NUM_IO_MODULES; m++) begin
                    if (cfg_io_write[m])
                        io_mem[m][cfg_io_addr] = cfg_io_wdata;
                end
            end
            if (cfg_io_read != '0) begin
                read_strobes++;
                seen_rsel = cfg_io_read;
            end
        end
    end

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] want);
        $display("error %0t: %s is %h, expected %h", $time, name, got, want);
        errors++;
    endtask

    // Present one command and hand over its bytes as the receiver takes them
    task automatic send_command(input cmd_id_t cmd, input int length, input cmd_buf_t bytes);
        int sent;
        int cycles;
        sent           = 0;
        cycles         = 0;
        ep4_cmd_id     = cmd;
        ep4_cmd_length = cmd_len_t'(length);
        ep4_data       = bytes[7:0];
        sending        = 1'b1;
        while (sent < length && cycles < CMD_CYCLES) begin
            @(posedge clk);
            if (ep4_read)
                sent++;
            cycles++;
            @(negedge clk);
            if (sent < length)
                ep4_data = bytes[8*sent +: 8];
        end
        sending = 1'b0;
        if (sent < length) begin
            $display("command bytes were not all read within %0d cycles", CMD_CYCLES);
            errors++;
        end
    endtask

    initial begin
        clk            = 1'b0;
        reset          = 1'b1;
        seed           = 32'hf486;
        ready_seed     = 32'hf486;
        sending        = 1'b0;
        ep4_ready_roll = 1'b0;
        ep8_ready      = 1'b0;
        ep4_cmd_id     = '0;
        // Nonzero so the idle receiver does not finish an empty command
        ep4_cmd_length = 16'd1;
        ep4_data       = '0;
        direction      = '0;
        errors         = 0;
        passed         = 0;
        read_pulses    = 0;
        write_strobes  = 0;
        read_strobes   = 0;
        for (int m = 0; m < `NUM_IO_MODULES; m++) begin
            for (int a = 0; a < `NUM_IO_REGS; a++) begin
                io_mem[m][a] = 8'hA5 ^ 8'(m * `NUM_IO_REGS + a);
                exp_io[m][a] = 8'hA5 ^ 8'(m * `NUM_IO_REGS + a);
            end
        end
        for (int p = 0; p < `NUM_PORTS; p++)
            exp_hwcon[p] = 8'h00;
        repeat (4) @(negedge clk);
        reset = 1'b0;

        for (int n = 0; n < NUM_CMDS; n++) begin
            kind = $unsigned($random(seed)) % 5;
            case (kind)
                0: id = `CMD_GET_HWCON;
                1: id = `CMD_SET_HWCON;
                2: id = `CMD_GET_IOREG;
                3: id = `CMD_SET_IOREG;
                default: begin
                    id = $random(seed);
                    if (id >= `CMD_GET_HWCON && id <= `CMD_SET_IOREG)
                        id = id ^ 8'h80;
                end
            endcase
            len     = 1 + ($unsigned($random(seed)) % `MAX_CMD_BYTES);
            payload = {$random(seed), $random(seed)};
            // Bytes past the length read as zero from a cleared buffer
            for (int i = 0; i < `MAX_CMD_BYTES; i++) begin
                if (i >= len)
                    payload[8*i +: 8] = 8'h00;
            end
            direction     = $random(seed);
            port          = payload[1:0];
            addr          = payload[9:8];
            mod_idx       = {direction[port], port};
            exp_sel       = io_sel_t'(1) << mod_idx;
            read_pulses   = 0;
            write_strobes = 0;
            read_strobes  = 0;
            errors_before = errors;
            exp_bytes.delete();
            rpl_bytes.delete();

            // Expected effect and reply bytes in the order they leave the endpoint
            case (id)
                `CMD_SET_HWCON: exp_hwcon[port] = payload[15:8];
                `CMD_SET_IOREG: exp_io[mod_idx][addr] = payload[23:16];
                `CMD_GET_HWCON: begin
                    exp_rpl_id = `RPL_DATA_HWCON;
                    exp_bytes.push_back(8'(port));
                    exp_bytes.push_back(exp_hwcon[port]);
                end
                `CMD_GET_IOREG: begin
                    exp_rpl_id = `RPL_DATA_IOREG;
                    exp_bytes.push_back(8'(port));
                    exp_bytes.push_back(8'(addr));
                    exp_bytes.push_back(exp_io[mod_idx][addr]);
                end
                default: ;
            endcase

            send_command(id, len, payload);
            // Window for the executor to act and a reply to start
            repeat (6) @(negedge clk);
            waited = 0;
            while (rpl_bytes.size() < exp_bytes.size() && waited < CMD_CYCLES) begin
                @(negedge clk);
                waited++;
            end
            repeat (2) @(negedge clk);

            if (read_pulses != len)
                report_mismatch("ep4_read count", read_pulses, len);
            if (hwcons !== {exp_hwcon[3], exp_hwcon[2], exp_hwcon[1], exp_hwcon[0]})
                report_mismatch("hwcons", hwcons,
                                {exp_hwcon[3], exp_hwcon[2], exp_hwcon[1], exp_hwcon[0]});
            if (id == `CMD_SET_IOREG) begin
                if (write_strobes != 1)
                    report_mismatch("cfg_io_write count", write_strobes, 1);
                if (seen_wsel !== exp_sel)
                    report_mismatch("cfg_io_write", seen_wsel, exp_sel);
                if (seen_waddr !== addr)
                    report_mismatch("cfg_io_addr", seen_waddr, addr);
                if (io_mem[mod_idx][addr] !== exp_io[mod_idx][addr])
                    report_mismatch("I/O register", io_mem[mod_idx][addr],
                                    exp_io[mod_idx][addr]);
            end else if (write_strobes != 0) begin
                report_mismatch("cfg_io_write count", write_strobes, 0);
            end
            if (read_strobes != ((id == `CMD_GET_IOREG) ? 1 : 0))
                report_mismatch("cfg_io_read count", read_strobes,
                                (id == `CMD_GET_IOREG) ? 1 : 0);
            else if (id == `CMD_GET_IOREG && seen_rsel !== exp_sel)
                report_mismatch("cfg_io_read", seen_rsel, exp_sel);
            if (rpl_bytes.size() != exp_bytes.size()) begin
                report_mismatch("reply byte count", rpl_bytes.size(), exp_bytes.size());
            end else if (exp_bytes.size() != 0) begin
                if (seen_rpl_id !== exp_rpl_id)
                    report_mismatch("ep8_cmd_id", seen_rpl_id, exp_rpl_id);
                if (seen_rpl_len !== cmd_len_t'(exp_bytes.size()))
                    report_mismatch("ep8_cmd_length", seen_rpl_len, exp_bytes.size());
                for (int i = 0; i < exp_bytes.size(); i++) begin
                    if (rpl_bytes[i] !== exp_bytes[i])
                        report_mismatch($sformatf("ep8_data byte %0d", i), rpl_bytes[i],
                                        exp_bytes[i]);
                end
            end
            if (errors == errors_before)
                passed++;
            $display("command %0d: id %h length %0d %s", n, id, len,
                     (errors == errors_before) ? "ok" : "mismatch");
        end

        $display("%0d commands, %0d passed, %0d failed, %0d errors", NUM_CMDS, passed,
                 NUM_CMDS - passed, errors);
        if (errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

    // Watchdog sized from the command count
    initial begin
        #(NUM_CMDS * CMD_CYCLES * PERIOD);
        $display("Run stopped by the watchdog after %0d cycles", NUM_CMDS * CMD_CYCLES);
        $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
+incdir+rtl
rtl/host_ctrl_pkg.sv
rtl/cmd_receiver.sv
rtl/cmd_executor.sv
rtl/reply_sender.sv
rtl/host_controller.sv
dv/host_controller_properties.sv
dv/host_controller_tb.sv

//--- Bender.yml
package:
  name: host_controller

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/host_ctrl_pkg.sv
      - rtl/cmd_receiver.sv
      - rtl/cmd_executor.sv
      - rtl/reply_sender.sv
      - rtl/host_controller.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - dv/host_controller_properties.sv
      - dv/host_controller_tb.sv
